//--- design/rf_params.svh
/*
 * Register file widths, register count and bank indices
 */

`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// Register number and operand widths
`define RF_ADDR_WIDTH 5
`define RF_DATA_WIDTH 32
`define RF_WORDS      32

// One RAM bank per read port
`define RF_BANKS      3
`define RF_BANK_A     0
`define RF_BANK_B     1
`define RF_BANK_DBG   2

`endif

//--- design/rf_pkg.sv
/*
 * Datapath types of the register file:
 * register numbers and operand values
 */

`include "rf_params.svh"

package rf_pkg;

   // Register number as seen by fetch, decode and commit
   typedef logic [`RF_ADDR_WIDTH-1:0] gpr_adr_t;

   // Operand or result word
   typedef logic [`RF_DATA_WIDTH-1:0] gpr_data_t;

endpackage

//--- design/dbg_pkg.sv
/*
 * Debug bus types: Wishbone register address
 * and the debug-read state machine encoding
 */

`include "rf_params.svh"

package dbg_pkg;

   typedef logic [`RF_ADDR_WIDTH-1:0] dbg_adr_t;

   typedef enum logic {
      DBG_IDLE,
      DBG_READ_ACK
   } dbg_state_e;

endpackage

//--- design/rf_bank_if.sv
/*
 * Per-bank connection: shared write port from the arbiter,
 * read request and read data for the bank's reader
 */

`timescale 1ns/1ps

interface rf_bank_if;
   import rf_pkg::*;

   // Write port, same request on every bank
   logic      we;
   gpr_adr_t  wadr;
   gpr_data_t wdat;

   // Read port of this bank
   logic      re;
   gpr_adr_t  radr;
   gpr_data_t rdat;

   modport writer (output we, wadr, wdat);
   modport reader (output re, radr, input rdat);
   modport bank   (input we, wadr, wdat, re, radr, output rdat);

endinterface

//--- design/rf_bank.sv
/*
 * Simple dual-port register RAM bank with a registered read port
 */

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_bank (
   input logic     clk,
   rf_bank_if.bank bank
);
   import rf_pkg::*;

   gpr_data_t mem [`RF_WORDS];

   always_ff @(posedge clk) begin
      if (bank.we) begin
         mem[bank.wadr] <= bank.wdat;
      end
   end

   // Read returns the old word on a same-edge write, no internal bypass
   always_ff @(posedge clk) begin
      if (bank.re) begin
         bank.rdat <= mem[bank.radr];
      end
   end

endmodule

//--- design/rf_port_arbiter.sv
/*
 * Wishbone classic debug slave for the register file
 * and the shared write port arbitration over all banks
 */

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_port_arbiter (
   input  logic                clk,
   input  logic                rst,
   input  logic                commit_we_i,
   input  rf_pkg::gpr_adr_t    commit_rfd_adr_i,
   input  rf_pkg::gpr_data_t   commit_result_i,
   input  logic                dbg_cyc_i,
   input  logic                dbg_stb_i,
   input  logic                dbg_we_i,
   input  dbg_pkg::dbg_adr_t   dbg_adr_i,
   input  rf_pkg::gpr_data_t   dbg_dat_i,
   output rf_pkg::gpr_data_t   dbg_dat_o,
   output logic                dbg_ack_o,
   rf_bank_if.writer           wr_ports [`RF_BANKS],
   rf_bank_if.reader           dbg_rd
);
   import rf_pkg::*;
   import dbg_pkg::*;

   dbg_state_e state;
   logic       dbg_req;
   logic       dbg_wr_ack;
   logic       wr_en;
   gpr_adr_t   wr_adr;
   gpr_data_t  wr_dat;

   assign dbg_req = dbg_cyc_i & dbg_stb_i;

   // Commit owns the write port, a debug write waits for a free cycle
   assign dbg_wr_ack = dbg_req & dbg_we_i & ~commit_we_i;

   assign wr_en  = commit_we_i | dbg_wr_ack;
   assign wr_adr = commit_we_i ? commit_rfd_adr_i : dbg_adr_i;
   assign wr_dat = commit_we_i ? commit_result_i : dbg_dat_i;

   for (genvar b = 0; b < `RF_BANKS; b++) begin : g_wr
      assign wr_ports[b].we   = wr_en;
      assign wr_ports[b].wadr = wr_adr;
      assign wr_ports[b].wdat = wr_dat;
   end

   // Debug read goes through the dedicated bank
   assign dbg_rd.re   = (state == DBG_IDLE) & dbg_req & ~dbg_we_i;
   assign dbg_rd.radr = dbg_adr_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= DBG_IDLE;
      end else begin
         case (state)
            DBG_IDLE: begin
               if (dbg_rd.re) begin
                  state <= DBG_READ_ACK;
               end
            end
            DBG_READ_ACK: state <= DBG_IDLE;
            default:      state <= DBG_IDLE;
         endcase
      end
   end

   // Bank data holds until the next debug read
   assign dbg_dat_o = dbg_rd.rdat;
   assign dbg_ack_o = dbg_wr_ack | ((state == DBG_READ_ACK) & dbg_req);

endmodule

//--- design/rf_bypass.sv
/*
 * Decode operand bypass from control and commit stages,
 * execute operand latch and execute-stage hazard tracking
 */

`timescale 1ns/1ps

module rf_bypass (
   input  logic              clk,
   input  logic              rst,
   input  logic              fetch_valid_i,
   input  rf_pkg::gpr_adr_t  fetch_rfa_adr_i,
   input  rf_pkg::gpr_adr_t  fetch_rfb_adr_i,
   input  rf_pkg::gpr_adr_t  decode_rfa_adr_i,
   input  rf_pkg::gpr_adr_t  decode_rfb_adr_i,
   input  logic              padv_decode_i,
   input  logic              execute_we_i,
   input  rf_pkg::gpr_adr_t  execute_rfd_adr_i,
   input  logic              ctrl_we_i,
   input  rf_pkg::gpr_adr_t  ctrl_rfd_adr_i,
   input  rf_pkg::gpr_data_t ctrl_result_i,
   input  logic              commit_we_i,
   input  rf_pkg::gpr_adr_t  commit_rfd_adr_i,
   input  rf_pkg::gpr_data_t commit_result_i,
   input  logic              pipeline_flush_i,
   output rf_pkg::gpr_data_t decode_rfa_o,
   output rf_pkg::gpr_data_t decode_rfb_o,
   output rf_pkg::gpr_data_t execute_rfa_o,
   output rf_pkg::gpr_data_t execute_rfb_o,
   rf_bank_if.reader         rd_a,
   rf_bank_if.reader         rd_b
);
   import rf_pkg::*;

   // Operand A at index 0, operand B at index 1
   localparam int N_OPS = 2;

   gpr_adr_t  fetch_adr  [N_OPS];
   gpr_adr_t  decode_adr [N_OPS];
   gpr_data_t ram_dat    [N_OPS];
   gpr_data_t decode_op  [N_OPS];
   gpr_data_t execute_op [N_OPS];
   logic      flushing;

   assign fetch_adr[0]  = fetch_rfa_adr_i;
   assign fetch_adr[1]  = fetch_rfb_adr_i;
   assign decode_adr[0] = decode_rfa_adr_i;
   assign decode_adr[1] = decode_rfb_adr_i;

   // Banks are read on the fetch edge
   assign rd_a.re   = fetch_valid_i;
   assign rd_a.radr = fetch_rfa_adr_i;
   assign rd_b.re   = fetch_valid_i;
   assign rd_b.radr = fetch_rfb_adr_i;
   assign ram_dat[0] = rd_a.rdat;
   assign ram_dat[1] = rd_b.rdat;

   // The execute destination is stale after a flush until decode advances
   always_ff @(posedge clk) begin
      if (rst) begin
         flushing <= 1'b0;
      end else if (pipeline_flush_i) begin
         flushing <= 1'b1;
      end else if (padv_decode_i) begin
         flushing <= 1'b0;
      end
   end

   for (genvar p = 0; p < N_OPS; p++) begin : g_op
      logic      ctrl_match;
      logic      commit_match;
      logic      last_hit;
      gpr_data_t last_res;
      logic      hazard;
      gpr_data_t execute_lat;

      assign ctrl_match   = ctrl_we_i & (ctrl_rfd_adr_i == decode_adr[p]);
      assign commit_match = commit_we_i & (commit_rfd_adr_i == decode_adr[p]);

      // Latest commit to the decode register since the fetch edge.
      // A commit on the fetch edge itself misses the RAM read.
      always_ff @(posedge clk) begin
         if (rst) begin
            last_hit <= 1'b0;
         end else if (fetch_valid_i) begin
            last_hit <= commit_we_i & (commit_rfd_adr_i == fetch_adr[p]);
         end else if (commit_match) begin
            last_hit <= 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (fetch_valid_i | commit_match) begin
            last_res <= commit_result_i;
         end
      end

      assign decode_op[p] = ctrl_match   ? ctrl_result_i :
                            commit_match ? commit_result_i :
                            last_hit     ? last_res :
                            ram_dat[p];

      always_ff @(posedge clk) begin
         if (padv_decode_i) begin
            execute_lat <= decode_op[p];
         end
      end

      // Producer still in execute when the operand left decode
      always_ff @(posedge clk) begin
         if (rst | pipeline_flush_i) begin
            hazard <= 1'b0;
         end else if (padv_decode_i) begin
            hazard <= execute_we_i & ~flushing &
                      (execute_rfd_adr_i == decode_adr[p]);
         end
      end

      assign execute_op[p] = hazard ? ctrl_result_i : execute_lat;
   end

   assign decode_rfa_o  = decode_op[0];
   assign decode_rfb_o  = decode_op[1];
   assign execute_rfa_o = execute_op[0];
   assign execute_rfb_o = execute_op[1];

endmodule

//--- design/rf_top.sv
/*
 * Register file top level: RAM banks, write port arbiter
 * with debug slave, and operand bypass
 */

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_top (
   input  logic              clk,
   input  logic              rst,
   input  logic              fetch_valid_i,
   input  rf_pkg::gpr_adr_t  fetch_rfa_adr_i,
   input  rf_pkg::gpr_adr_t  fetch_rfb_adr_i,
   input  rf_pkg::gpr_adr_t  decode_rfa_adr_i,
   input  rf_pkg::gpr_adr_t  decode_rfb_adr_i,
   input  logic              padv_decode_i,
   input  logic              execute_we_i,
   input  rf_pkg::gpr_adr_t  execute_rfd_adr_i,
   input  logic              ctrl_we_i,
   input  rf_pkg::gpr_adr_t  ctrl_rfd_adr_i,
   input  rf_pkg::gpr_data_t ctrl_result_i,
   input  logic              commit_we_i,
   input  rf_pkg::gpr_adr_t  commit_rfd_adr_i,
   input  rf_pkg::gpr_data_t commit_result_i,
   input  logic              pipeline_flush_i,
   output rf_pkg::gpr_data_t decode_rfa_o,
   output rf_pkg::gpr_data_t decode_rfb_o,
   output rf_pkg::gpr_data_t execute_rfa_o,
   output rf_pkg::gpr_data_t execute_rfb_o,
   input  logic              dbg_cyc_i,
   input  logic              dbg_stb_i,
   input  logic              dbg_we_i,
   input  dbg_pkg::dbg_adr_t dbg_adr_i,
   input  rf_pkg::gpr_data_t dbg_dat_i,
   output rf_pkg::gpr_data_t dbg_dat_o,
   output logic              dbg_ack_o
);

   rf_bank_if bank_if [`RF_BANKS] ();

   for (genvar g = 0; g < `RF_BANKS; g++) begin : g_bank
      rf_bank u_bank (
         .clk  (clk),
         .bank (bank_if[g])
      );
   end

   rf_port_arbiter u_arbiter (
      .clk              (clk),
      .rst              (rst),
      .commit_we_i      (commit_we_i),
      .commit_rfd_adr_i (commit_rfd_adr_i),
      .commit_result_i  (commit_result_i),
      .dbg_cyc_i        (dbg_cyc_i),
      .dbg_stb_i        (dbg_stb_i),
      .dbg_we_i         (dbg_we_i),
      .dbg_adr_i        (dbg_adr_i),
      .dbg_dat_i        (dbg_dat_i),
      .dbg_dat_o        (dbg_dat_o),
      .dbg_ack_o        (dbg_ack_o),
      .wr_ports         (bank_if),
      .dbg_rd           (bank_if[`RF_BANK_DBG])
   );

   rf_bypass u_bypass (
      .clk               (clk),
      .rst               (rst),
      .fetch_valid_i     (fetch_valid_i),
      .fetch_rfa_adr_i   (fetch_rfa_adr_i),
      .fetch_rfb_adr_i   (fetch_rfb_adr_i),
      .decode_rfa_adr_i  (decode_rfa_adr_i),
      .decode_rfb_adr_i  (decode_rfb_adr_i),
      .padv_decode_i     (padv_decode_i),
      .execute_we_i      (execute_we_i),
      .execute_rfd_adr_i (execute_rfd_adr_i),
      .ctrl_we_i         (ctrl_we_i),
      .ctrl_rfd_adr_i    (ctrl_rfd_adr_i),
      .ctrl_result_i     (ctrl_result_i),
      .commit_we_i       (commit_we_i),
      .commit_rfd_adr_i  (commit_rfd_adr_i),
      .commit_result_i   (commit_result_i),
      .pipeline_flush_i  (pipeline_flush_i),
      .decode_rfa_o      (decode_rfa_o),
      .decode_rfb_o      (decode_rfb_o),
      .execute_rfa_o     (execute_rfa_o),
      .execute_rfb_o     (execute_rfb_o),
      .rd_a              (bank_if[`RF_BANK_A]),
      .rd_b              (bank_if[`RF_BANK_B])
   );

endmodule

//--- tests/tb_clk_gen.sv
/*
 * Testbench clock and reset: 4 ns clock, reset held for 5 cycles
 */

`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (5) @(posedge clk_o);
      #1 rst_o = 1'b0;
   end

endmodule

//--- tests/rf_tb.sv
/*
 * Register file testbench with stimulus, a reference model of the
 * registers and bypass rules, and compare tasks on the DUT outputs
 */

`timescale 1ns/1ps

`include "rf_params.svh"

module rf_tb;
   import rf_pkg::*;
   import dbg_pkg::*;

   logic clk, rst;
   logic fetch_valid_i, padv_decode_i, execute_we_i, ctrl_we_i, commit_we_i;
   logic pipeline_flush_i, dbg_cyc_i, dbg_stb_i, dbg_we_i, dbg_ack_o;
   gpr_adr_t fetch_rfa_adr_i, fetch_rfb_adr_i, decode_rfa_adr_i, decode_rfb_adr_i;
   gpr_adr_t execute_rfd_adr_i, ctrl_rfd_adr_i, commit_rfd_adr_i;
   dbg_adr_t dbg_adr_i;
   gpr_data_t ctrl_result_i, commit_result_i, dbg_dat_i, dbg_dat_o;
   gpr_data_t decode_rfa_o, decode_rfb_o, execute_rfa_o, execute_rfb_o;

   // Reference state
   gpr_data_t model [`RF_WORDS];
   gpr_data_t exe_lat_m [2];
   logic [1:0] haz_m;
   logic flushing_m;
   logic chk_dec, chk_exe;
   int errors, n_checks;

   tb_clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst));

   rf_top rf_top_i (.*);

   // Decode priority is control stage, then commit, then the committed registers
   function automatic gpr_data_t ref_operand(gpr_adr_t adr);
      if (ctrl_we_i && ctrl_rfd_adr_i == adr) return ctrl_result_i;
      if (commit_we_i && commit_rfd_adr_i == adr) return commit_result_i;
      return model[adr];
   endfunction

   function automatic gpr_adr_t pick_adr(gpr_adr_t a, gpr_adr_t b);
      logic [1:0] sel = 2'($urandom());
      return (sel == 2'd0) ? a : (sel == 2'd1) ? b : gpr_adr_t'($urandom());
   endfunction

   task automatic check_operand(string name, gpr_data_t got, gpr_data_t exp);
      n_checks++;
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_ack(string name, logic got, logic exp);
      n_checks++;
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Register and hazard model updated on the same edges as the DUT
   always @(posedge clk) begin
      if (padv_decode_i) begin
         exe_lat_m[0] = ref_operand(decode_rfa_adr_i);
         exe_lat_m[1] = ref_operand(decode_rfb_adr_i);
      end
      if (rst || pipeline_flush_i) begin
         haz_m = 2'b00;
      end else if (padv_decode_i) begin
         haz_m[0] = execute_we_i & ~flushing_m & (execute_rfd_adr_i == decode_rfa_adr_i);
         haz_m[1] = execute_we_i & ~flushing_m & (execute_rfd_adr_i == decode_rfb_adr_i);
      end
      if (rst) flushing_m = 1'b0;
      else if (pipeline_flush_i) flushing_m = 1'b1;
      else if (padv_decode_i) flushing_m = 1'b0;
      if (commit_we_i) model[commit_rfd_adr_i] = commit_result_i;
      else if (dbg_cyc_i && dbg_stb_i && dbg_we_i) model[dbg_adr_i] = dbg_dat_i;
   end

   // Compare process samples in mid cycle
   always @(negedge clk) begin
      if (chk_dec) begin
         check_operand("decode_rfa_o", decode_rfa_o, ref_operand(decode_rfa_adr_i));
         check_operand("decode_rfb_o", decode_rfb_o, ref_operand(decode_rfb_adr_i));
      end
      if (chk_exe) begin
         check_operand("execute_rfa_o", execute_rfa_o, haz_m[0] ? ctrl_result_i : exe_lat_m[0]);
         check_operand("execute_rfb_o", execute_rfb_o, haz_m[1] ? ctrl_result_i : exe_lat_m[1]);
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Returns at the ack negedge with the cycle count after the first sample
   task automatic wait_ack(output int n);
      n = 0;
      @(negedge clk);
      while (!dbg_ack_o && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (!dbg_ack_o) begin
         $display("Timeout: no debug ack within 20 cycles");
         errors++;
      end
   endtask

   task automatic dbg_write(gpr_adr_t adr, gpr_data_t dat);
      int n;
      dbg_cyc_i = 1'b1;
      dbg_stb_i = 1'b1;
      dbg_we_i  = 1'b1;
      dbg_adr_i = adr;
      dbg_dat_i = dat;
      wait_ack(n);
      next_cycle();
      dbg_cyc_i = 1'b0;
      dbg_stb_i = 1'b0;
      dbg_we_i  = 1'b0;
   endtask

   task automatic dbg_read(gpr_adr_t adr);
      int n;
      gpr_data_t exp;
      exp = model[adr];
      dbg_cyc_i = 1'b1;
      dbg_stb_i = 1'b1;
      dbg_we_i  = 1'b0;
      dbg_adr_i = adr;
      wait_ack(n);
      if (n != 1) begin
         $display("Error: debug read ack came %0d cycles after the request, not 1", n);
         errors++;
      end
      check_operand("dbg_dat_o", dbg_dat_o, exp);
      next_cycle();
      dbg_cyc_i = 1'b0;
      dbg_stb_i = 1'b0;
      // Arbiter spends one idle cycle after the ack
      next_cycle();
   endtask

   task automatic fetch(gpr_adr_t a, gpr_adr_t b, logic commit_at_fetch);
      fetch_valid_i   = 1'b1;
      fetch_rfa_adr_i = a;
      fetch_rfb_adr_i = b;
      commit_we_i     = commit_at_fetch;
      commit_rfd_adr_i = pick_adr(a, b);
      commit_result_i = $urandom();
      next_cycle();
      fetch_valid_i    = 1'b0;
      commit_we_i      = 1'b0;
      decode_rfa_adr_i = a;
      decode_rfb_adr_i = b;
      chk_dec          = 1'b1;
   endtask

   task automatic run_decode(int n_fetch, logic writes);
      gpr_adr_t a, b;
      repeat (n_fetch) begin
         a = gpr_adr_t'($urandom());
         b = gpr_adr_t'($urandom());
         fetch(a, b, writes & 1'($urandom()));
         repeat (6) begin
            ctrl_we_i        = writes & 1'($urandom());
            ctrl_rfd_adr_i   = pick_adr(a, b);
            ctrl_result_i    = $urandom();
            commit_we_i      = writes & 1'($urandom());
            commit_rfd_adr_i = pick_adr(a, b);
            commit_result_i  = $urandom();
            next_cycle();
         end
         ctrl_we_i   = 1'b0;
         commit_we_i = 1'b0;
      end
   endtask

   task automatic advance(logic match);
      padv_decode_i     = 1'b1;
      execute_we_i      = 1'b1;
      execute_rfd_adr_i = match ? decode_rfa_adr_i : ~decode_rfa_adr_i;
      next_cycle();
      padv_decode_i = 1'b0;
      execute_we_i  = 1'b0;
      chk_exe       = 1'b1;
      repeat (3) begin
         ctrl_result_i = $urandom();
         next_cycle();
      end
   endtask

   initial begin
      int n;
      gpr_adr_t x;
      void'($urandom(13529));
      {fetch_valid_i, padv_decode_i, execute_we_i, ctrl_we_i, commit_we_i} = '0;
      {pipeline_flush_i, dbg_cyc_i, dbg_stb_i, dbg_we_i} = '0;
      {fetch_rfa_adr_i, fetch_rfb_adr_i, decode_rfa_adr_i, decode_rfb_adr_i} = '0;
      {execute_rfd_adr_i, ctrl_rfd_adr_i, commit_rfd_adr_i, dbg_adr_i} = '0;
      {ctrl_result_i, commit_result_i, dbg_dat_i} = '0;
      {chk_dec, chk_exe, errors, n_checks} = '0;
      n = 0;
      while (rst && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (rst) begin
         $display("Timeout: reset never released");
         errors++;
      end
      #1;
      check_ack("dbg_ack_o", dbg_ack_o, 1'b0);
      // Preload, then plain reads and bypassed reads in decode
      for (int i = 0; i < `RF_WORDS; i++) dbg_write(gpr_adr_t'(i), $urandom());
      run_decode(8, 1'b0);
      run_decode(12, 1'b1);
      // Execute latch and hazard on both operands, then a flush clearing
      // the hazard and suppressing it for one advance
      x = gpr_adr_t'($urandom());
      fetch(x, x, 1'b0);
      advance(1'b0);
      advance(1'b1);
      pipeline_flush_i = 1'b1;
      next_cycle();
      pipeline_flush_i = 1'b0;
      advance(1'b1);
      advance(1'b1);
      // Debug port only while decode is empty
      chk_dec = 1'b0;
      repeat (8) begin
         x = gpr_adr_t'($urandom());
         dbg_write(x, $urandom());
         dbg_read(x);
      end
      // Debug write held off by commits
      x = gpr_adr_t'($urandom());
      dbg_cyc_i = 1'b1;
      dbg_stb_i = 1'b1;
      dbg_we_i  = 1'b1;
      dbg_adr_i = x;
      dbg_dat_i = $urandom();
      for (int k = 0; k < 4; k++) begin
         commit_we_i      = 1'b1;
         commit_rfd_adr_i = (k == 0) ? x : x + gpr_adr_t'(1);
         commit_result_i  = $urandom();
         @(negedge clk);
         check_ack("dbg_ack_o", dbg_ack_o, 1'b0);
         next_cycle();
      end
      commit_we_i = 1'b0;
      wait_ack(n);
      next_cycle();
      {dbg_cyc_i, dbg_stb_i, dbg_we_i} = '0;
      dbg_read(x);
      dbg_read(x + gpr_adr_t'(1));
      $display("Checks: %0d, errors: %0d", n_checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- regfile_bypass.f
+incdir+design
design/rf_pkg.sv
design/dbg_pkg.sv
design/rf_bank_if.sv
design/rf_bank.sv
design/rf_port_arbiter.sv
design/rf_bypass.sv
design/rf_top.sv
tests/tb_clk_gen.sv
tests/rf_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the register file testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f regfile_bypass.f --top-module rf_tb -Mdir obj_dir -o rf_sim
./obj_dir/rf_sim | tee sim.log

if grep -q "all tests passed" sim.log; then
   exit 0
else
   echo "Simulation did not pass, see sim.log"
   exit 1
fi
